// ==== verilog/isa_pkg.sv ====
// RV32 integer subset used by the decode and issue stage.
// Only ADD, SUB, AND, OR, XOR, ADDI, ANDI, ORI, LUI and MUL are encoded.
// Anything else decodes as illegal.
package isa_pkg;

  // Register file geometry
  localparam int XLEN          = 32;
  localparam int NUM_REGS      = 32;
  localparam int REG_ADDR_BITS = $clog2(NUM_REGS);

  // ----------------------------------------------------------------------
  // Major opcodes
  // ----------------------------------------------------------------------
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;

  // funct3 values, shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  // MUL reuses funct3 000 under the M funct7
  localparam logic [2:0] F3_MUL = 3'b000;

  // funct7 values
  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

  // Micro-ops seen by the execute pipes
  typedef enum logic [3:0] {
    UOP_ADD, UOP_SUB, UOP_AND, UOP_OR, UOP_XOR,
    UOP_ADDI, UOP_ANDI, UOP_ORI, UOP_LUI, UOP_MUL
  } rv_uop;

  // Immediate formats
  typedef enum logic {
    IMM_I,
    IMM_U
  } rv_imm_type;

endpackage

// ==== verilog/pipe_pkg.sv ====
// Payloads between fetch, decode, the execute pipes and completion.
// Two pipes with fixed subsets: pipe 0 takes ALU ops, pipe 1 takes MUL.
package pipe_pkg;

  localparam int NUM_PIPES = 2;
  localparam int SEQ_BITS  = 8;

  // ----------------------------------------------------------------------
  // Pipe subsets, one bit per micro-op encoding
  // ----------------------------------------------------------------------
  localparam int UOP_SET_BITS = 1 << $bits(isa_pkg::rv_uop);

  localparam logic [UOP_SET_BITS-1:0] ALU_SET =
    (UOP_SET_BITS'(1) << isa_pkg::UOP_ADD)  | (UOP_SET_BITS'(1) << isa_pkg::UOP_SUB)  |
    (UOP_SET_BITS'(1) << isa_pkg::UOP_AND)  | (UOP_SET_BITS'(1) << isa_pkg::UOP_OR)   |
    (UOP_SET_BITS'(1) << isa_pkg::UOP_XOR)  | (UOP_SET_BITS'(1) << isa_pkg::UOP_ADDI) |
    (UOP_SET_BITS'(1) << isa_pkg::UOP_ANDI) | (UOP_SET_BITS'(1) << isa_pkg::UOP_ORI)  |
    (UOP_SET_BITS'(1) << isa_pkg::UOP_LUI);

  localparam logic [UOP_SET_BITS-1:0] MUL_SET = UOP_SET_BITS'(1) << isa_pkg::UOP_MUL;

  // Index k is the subset of pipe k
  localparam logic [NUM_PIPES-1:0][UOP_SET_BITS-1:0] PIPE_SUBSETS = {MUL_SET, ALU_SET};

  // Fetch to decode
  typedef struct packed {
    logic [31:0]         inst;
    logic [31:0]         pc;
    logic [SEQ_BITS-1:0] seq_num;
  } fetch_req_t;

  // Decode to any execute pipe
  typedef struct packed {
    logic [31:0]                        pc;
    logic [isa_pkg::XLEN-1:0]           op1;
    logic [isa_pkg::XLEN-1:0]           op2;
    isa_pkg::rv_uop                     uop;
    logic [isa_pkg::REG_ADDR_BITS-1:0]  waddr;
    logic [SEQ_BITS-1:0]                seq_num;
  } issue_t;

  // Execute pipe back to the register file
  typedef struct packed {
    logic [isa_pkg::REG_ADDR_BITS-1:0] waddr;
    logic [isa_pkg::XLEN-1:0]          wdata;
    logic                              wen;
    logic [SEQ_BITS-1:0]               seq_num;
  } complete_t;

endpackage

// ==== verilog/inst_decoder.sv ====
// Combinational decoder for the supported RV32 subset.
// Unused source fields read as x0 so they never cause a stall.
// XORI and every other encoding outside the subset report legal low.
`timescale 1ns/1ps

module inst_decoder (
  input  logic [31:0]                       inst,
  output logic                              legal,
  output isa_pkg::rv_uop                    uop,
  output logic [isa_pkg::REG_ADDR_BITS-1:0] raddr0,
  output logic [isa_pkg::REG_ADDR_BITS-1:0] raddr1,
  output logic [isa_pkg::REG_ADDR_BITS-1:0] waddr,
  output logic                              wen,
  output isa_pkg::rv_imm_type               imm_sel,
  output logic                              op2_sel
);

  // Instruction fields
  logic [6:0]                        opcode;
  logic [2:0]                        funct3;
  logic [6:0]                        funct7;
  logic [isa_pkg::REG_ADDR_BITS-1:0] rd;
  logic [isa_pkg::REG_ADDR_BITS-1:0] rs1;
  logic [isa_pkg::REG_ADDR_BITS-1:0] rs2;

  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct7 = inst[31:25];

  always_comb begin
    // Safe defaults: illegal, no reads, no write
    legal   = 1'b0;
    uop     = isa_pkg::UOP_ADD;
    raddr0  = '0;
    raddr1  = '0;
    imm_sel = isa_pkg::IMM_I;
    op2_sel = 1'b0;

    case (opcode)
      // Register-register, two sources
      isa_pkg::OPC_OP: begin
        raddr0 = rs1;
        raddr1 = rs2;
        legal  = 1'b1;
        case ({funct7, funct3})
          {isa_pkg::F7_BASE,   isa_pkg::F3_ADD}: uop = isa_pkg::UOP_ADD;
          {isa_pkg::F7_ALT,    isa_pkg::F3_ADD}: uop = isa_pkg::UOP_SUB;
          {isa_pkg::F7_BASE,   isa_pkg::F3_AND}: uop = isa_pkg::UOP_AND;
          {isa_pkg::F7_BASE,   isa_pkg::F3_OR}:  uop = isa_pkg::UOP_OR;
          {isa_pkg::F7_BASE,   isa_pkg::F3_XOR}: uop = isa_pkg::UOP_XOR;
          {isa_pkg::F7_MULDIV, isa_pkg::F3_MUL}: uop = isa_pkg::UOP_MUL;
          default: legal = 1'b0;
        endcase
      end
      // Register-immediate, rs2 field is immediate bits
      isa_pkg::OPC_OPIMM: begin
        raddr0  = rs1;
        op2_sel = 1'b1;
        legal   = 1'b1;
        case (funct3)
          isa_pkg::F3_ADD: uop = isa_pkg::UOP_ADDI;
          isa_pkg::F3_AND: uop = isa_pkg::UOP_ANDI;
          isa_pkg::F3_OR:  uop = isa_pkg::UOP_ORI;
          default:         legal = 1'b0;
        endcase
      end
      // LUI: op1 reads x0, op2 is the U immediate
      isa_pkg::OPC_LUI: begin
        uop     = isa_pkg::UOP_LUI;
        imm_sel = isa_pkg::IMM_U;
        op2_sel = 1'b1;
        legal   = 1'b1;
      end
      default: legal = 1'b0;
    endcase

    // Writes to x0 are dropped
    waddr = legal ? rd : '0;
    wen   = legal && (rd != '0);
  end

endmodule

// ==== verilog/imm_gen.sv ====
// Immediate builder for the I and U formats only.
// I is sign-extended from bit 31, U fills the upper 20 bits.
`timescale 1ns/1ps

module imm_gen (
  input  logic [31:0]         inst,
  input  isa_pkg::rv_imm_type imm_sel,
  output logic [31:0]         imm
);

  always_comb begin
    case (imm_sel)
      // ADDI, ANDI, ORI
      isa_pkg::IMM_I: imm = {{20{inst[31]}}, inst[31:20]};
      // LUI, low 12 bits zero
      isa_pkg::IMM_U: imm = {inst[31:12], 12'b0};
      default:        imm = '0;
    endcase
  end

endmodule

// ==== verilog/regfile_pending.sv ====
// Register file with one pending bit per register.
// Asynchronous reads, no bypass: a write is visible the cycle after.
// x0 reads zero and is never pending. Set and clear of the same
// register in one cycle is excluded by the WAW stall upstream.
`timescale 1ns/1ps

module regfile_pending (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [isa_pkg::REG_ADDR_BITS-1:0] raddr0,
  input  logic [isa_pkg::REG_ADDR_BITS-1:0] raddr1,
  output logic [isa_pkg::XLEN-1:0]          rdata0,
  output logic [isa_pkg::XLEN-1:0]          rdata1,
  input  logic                              complete_val,
  input  pipe_pkg::complete_t               complete,
  input  logic                              set_val,
  input  logic [isa_pkg::REG_ADDR_BITS-1:0] set_addr,
  input  logic [isa_pkg::REG_ADDR_BITS-1:0] check_addr,
  output logic                              read_pending0,
  output logic                              read_pending1,
  output logic                              check_pending
);

  logic [isa_pkg::XLEN-1:0] regs [isa_pkg::NUM_REGS];
  logic [isa_pkg::NUM_REGS-1:0] pending;
  logic                         wr_en;

  // Completion write, x0 filtered here
  assign wr_en = complete_val && complete.wen && (complete.waddr != '0);

  // ----------------------------------------------------------------------
  // Register storage
  // ----------------------------------------------------------------------
  // Cleared on reset so every register starts at zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < isa_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[complete.waddr] <= complete.wdata;
    end
  end

  // Pending bits: clear on completion, set on issue
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      if (wr_en)
        pending[complete.waddr] <= 1'b0;
      if (set_val && (set_addr != '0))
        pending[set_addr] <= 1'b1;
    end
  end

  // Reads, x0 forced to zero
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

  // Pending lookups for both sources and the destination
  assign read_pending0 = pending[raddr0];
  assign read_pending1 = pending[raddr1];
  assign check_pending = pending[check_addr];

endmodule

// ==== verilog/issue_router.sv ====
// Steers one issue request to the pipe whose subset holds the micro-op.
// The lowest-numbered matching pipe wins. A micro-op that no pipe
// supports raises no valid and never transfers.
`timescale 1ns/1ps

module issue_router (
  input  isa_pkg::rv_uop                 uop,
  input  logic                           req_val,
  input  logic [pipe_pkg::NUM_PIPES-1:0] issue_rdy,
  output logic [pipe_pkg::NUM_PIPES-1:0] issue_val,
  output logic                           xfer
);

  logic                                   found;
  logic [$clog2(pipe_pkg::NUM_PIPES)-1:0] target;

  // Search the subset tables, highest index first so pipe 0 wins ties
  always_comb begin
    found  = 1'b0;
    target = '0;
    for (int k = pipe_pkg::NUM_PIPES - 1; k >= 0; k--) begin
      if (pipe_pkg::PIPE_SUBSETS[k][uop]) begin
        found  = 1'b1;
        target = k[$clog2(pipe_pkg::NUM_PIPES)-1:0];
      end
    end
  end

  // One-hot valid toward the chosen pipe
  always_comb begin
    issue_val = '0;
    if (req_val && found)
      issue_val[target] = 1'b1;
  end

  // Handshake done when the chosen pipe is ready
  assign xfer = |(issue_val & issue_rdy);

endmodule

// ==== verilog/decode_issue_unit.sv ====
// In-order, single-issue decode and issue stage.
// Stalls on any pending source or destination, covering RAW and WAW.
// An illegal instruction is never issued and blocks fetch for good.
// Completions carry no back-pressure; seq_num is passed, not checked.
`timescale 1ns/1ps

module decode_issue_unit (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           fetch_val,
  input  pipe_pkg::fetch_req_t           fetch_req,
  output logic                           fetch_rdy,
  output logic [pipe_pkg::NUM_PIPES-1:0] issue_val,
  input  logic [pipe_pkg::NUM_PIPES-1:0] issue_rdy,
  output pipe_pkg::issue_t               issue,
  input  logic                           complete_val,
  input  pipe_pkg::complete_t            complete
);

  // ----------------------------------------------------------------------
  // Fetch pipeline register
  // ----------------------------------------------------------------------
  pipe_pkg::fetch_req_t fetch_q;
  logic                 fetch_valid;
  logic                 fetch_xfer;
  logic                 issue_xfer;

  assign fetch_xfer = fetch_val && fetch_rdy;

  // Empty, or leaving this cycle
  assign fetch_rdy = !fetch_valid || issue_xfer;

  always_ff @(posedge clk) begin
    if (rst)
      fetch_valid <= 1'b0;
    else if (fetch_xfer)
      fetch_valid <= 1'b1;
    else if (issue_xfer)
      fetch_valid <= 1'b0;
  end

  // Payload, loaded only on accept
  always_ff @(posedge clk) begin
    if (fetch_xfer)
      fetch_q <= fetch_req;
  end

  // ----------------------------------------------------------------------
  // Decode, operands and stall
  // ----------------------------------------------------------------------
  logic                              dec_legal;
  isa_pkg::rv_uop                    dec_uop;
  logic [isa_pkg::REG_ADDR_BITS-1:0] dec_raddr0;
  logic [isa_pkg::REG_ADDR_BITS-1:0] dec_raddr1;
  logic [isa_pkg::REG_ADDR_BITS-1:0] dec_waddr;
  logic                              dec_wen;
  isa_pkg::rv_imm_type               dec_imm_sel;
  logic                              dec_op2_sel;
  logic [isa_pkg::XLEN-1:0]          rdata0;
  logic [isa_pkg::XLEN-1:0]          rdata1;
  logic [31:0]                       imm;
  logic                              read_pending0;
  logic                              read_pending1;
  logic                              check_pending;
  logic                              stall;
  logic                              req_val;

  inst_decoder decoder_i (
    .inst    (fetch_q.inst),
    .legal   (dec_legal),
    .uop     (dec_uop),
    .raddr0  (dec_raddr0),
    .raddr1  (dec_raddr1),
    .waddr   (dec_waddr),
    .wen     (dec_wen),
    .imm_sel (dec_imm_sel),
    .op2_sel (dec_op2_sel)
  );

  imm_gen imm_gen_i (
    .inst    (fetch_q.inst),
    .imm_sel (dec_imm_sel),
    .imm     (imm)
  );

  // Destination marked pending on the issue edge
  regfile_pending regfile_i (
    .clk           (clk),
    .rst           (rst),
    .raddr0        (dec_raddr0),
    .raddr1        (dec_raddr1),
    .rdata0        (rdata0),
    .rdata1        (rdata1),
    .complete_val  (complete_val),
    .complete      (complete),
    .set_val       (issue_xfer && dec_wen),
    .set_addr      (dec_waddr),
    .check_addr    (dec_waddr),
    .read_pending0 (read_pending0),
    .read_pending1 (read_pending1),
    .check_pending (check_pending)
  );

  // RAW on either source, WAW on the destination
  assign stall   = read_pending0 || read_pending1 || check_pending;
  assign req_val = fetch_valid && dec_legal && !stall;

  issue_router router_i (
    .uop       (dec_uop),
    .req_val   (req_val),
    .issue_rdy (issue_rdy),
    .issue_val (issue_val),
    .xfer      (issue_xfer)
  );

  // Shared payload toward both pipes
  always_comb begin
    issue.pc      = fetch_q.pc;
    issue.op1     = rdata0;
    issue.op2     = dec_op2_sel ? imm : rdata1;
    issue.uop     = dec_uop;
    issue.waddr   = dec_waddr;
    issue.seq_num = fetch_q.seq_num;
  end

endmodule

// ==== tests/decode_issue_sva.sv ====
// Handshake and stall rules for the decode and issue stage.
// Bound into every decode_issue_unit instance.
`timescale 1ns/1ps

module decode_issue_sva (
  input logic                           clk,
  input logic                           rst,
  input logic                           fetch_rdy,
  input logic [pipe_pkg::NUM_PIPES-1:0] issue_val,
  input logic [pipe_pkg::NUM_PIPES-1:0] issue_rdy,
  input pipe_pkg::issue_t               issue
);

  // Single issue, one pipe at most
  one_pipe_a: assert property (@(posedge clk) disable iff (rst) $onehot0(issue_val))
    else $error("more than one issue_val bit high: %b", issue_val);

  // Idle and ready in the first cycle out of reset
  reset_state_a: assert property (@(posedge clk) $fell(rst) |-> (issue_val == '0) && fetch_rdy)
    else $error("reset state wrong: issue_val=%b fetch_rdy=%b", issue_val, fetch_rdy);

  // Held request keeps its target pipe and payload until it transfers
  stall_stable_a: assert property (@(posedge clk) disable iff (rst)
    (|issue_val) && !(|(issue_val & issue_rdy)) |=> $stable(issue_val) && $stable(issue))
    else $error("stalled issue changed before transfer");

endmodule

bind decode_issue_unit decode_issue_sva sva_i (
  .clk       (clk),
  .rst       (rst),
  .fetch_rdy (fetch_rdy),
  .issue_val (issue_val),
  .issue_rdy (issue_rdy),
  .issue     (issue)
);

// ==== tests/decode_issue_tb.sv ====
// Trace-driven testbench for the decode and issue stage.
// Models both execute pipes with random ready gaps and 1 to 4 cycle
// completion delays. Trace lines must be legal and in program order.
// Run from the project root so the trace path resolves.
`timescale 1ns/1ps

module decode_issue_tb;

  logic                           clk;
  logic                           rst;
  logic                           fetch_val;
  pipe_pkg::fetch_req_t           fetch_req;
  logic                           fetch_rdy;
  logic [pipe_pkg::NUM_PIPES-1:0] issue_val;
  logic [pipe_pkg::NUM_PIPES-1:0] issue_rdy;
  pipe_pkg::issue_t               issue;
  logic                           complete_val;
  pipe_pkg::complete_t            complete;

  // Trace columns with one entry per line
  logic [31:0] t_inst[$];
  logic [31:0] t_pc[$];
  int          t_pipe[$];
  logic [31:0] t_op1[$];
  logic [31:0] t_op2[$];
  int          t_waddr[$];
  logic [31:0] t_result[$];
  int          n_lines;
  bit          trace_loaded;

  // Scoreboard state
  int          fetch_idx;
  int          issue_idx;
  int          offered;
  bit [31:0]   busy;
  int          fly_line[$];
  int          fly_wait[$];
  int          done_q[$];
  int          next_delay;
  int          errors;
  int          checks;

  decode_issue_unit dut_i (
    .clk          (clk),
    .rst          (rst),
    .fetch_val    (fetch_val),
    .fetch_req    (fetch_req),
    .fetch_rdy    (fetch_rdy),
    .issue_val    (issue_val),
    .issue_rdy    (issue_rdy),
    .issue        (issue),
    .complete_val (complete_val),
    .complete     (complete)
  );

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  // Source fields {rs1, rs2} with x0 for any unused field
  function automatic logic [9:0] source_regs(input logic [31:0] inst);
    logic [4:0] rs1;
    logic [4:0] rs2;
    rs1 = 5'd0;
    rs2 = 5'd0;
    if (inst[6:0] == 7'h33) begin
      rs1 = inst[19:15];
      rs2 = inst[24:20];
    end else if (inst[6:0] == 7'h13) begin
      rs1 = inst[19:15];
    end
    return {rs1, rs2};
  endfunction

  // Micro-op named by the standard RV32 encoding
  function automatic isa_pkg::rv_uop expected_uop(input logic [31:0] inst);
    isa_pkg::rv_uop u;
    u = isa_pkg::UOP_ADD;
    if (inst[6:0] == 7'h37) begin
      u = isa_pkg::UOP_LUI;
    end else if (inst[6:0] == 7'h13) begin
      case (inst[14:12])
        3'h6:    u = isa_pkg::UOP_ORI;
        3'h7:    u = isa_pkg::UOP_ANDI;
        default: u = isa_pkg::UOP_ADDI;
      endcase
    end else if (inst[31:25] == 7'h01) begin
      u = isa_pkg::UOP_MUL;
    end else if (inst[31:25] == 7'h20) begin
      u = isa_pkg::UOP_SUB;
    end else begin
      case (inst[14:12])
        3'h4:    u = isa_pkg::UOP_XOR;
        3'h6:    u = isa_pkg::UOP_OR;
        3'h7:    u = isa_pkg::UOP_AND;
        default: u = isa_pkg::UOP_ADD;
      endcase
    end
    return u;
  endfunction

  task automatic load_trace();
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] f_inst;
    logic [31:0] f_pc;
    logic [31:0] f_op1;
    logic [31:0] f_op2;
    logic [31:0] f_res;
    int          f_pipe;
    int          f_waddr;
    fd = $fopen("tests/decode_issue_trace.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the trace file tests/decode_issue_trace.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        cnt  = $fgets(line, fd);
        // Skip blank and comment lines
        if (cnt > 0 && line.len() > 1 && line.getc(0) != "#") begin
          cnt = $sscanf(line, "%h %h %d %h %h %d %h",
                        f_inst, f_pc, f_pipe, f_op1, f_op2, f_waddr, f_res);
          if (cnt == 7) begin
            t_inst.push_back(f_inst);
            t_pc.push_back(f_pc);
            t_pipe.push_back(f_pipe);
            t_op1.push_back(f_op1);
            t_op2.push_back(f_op2);
            t_waddr.push_back(f_waddr);
            t_result.push_back(f_res);
          end else begin
            errors++;
            $display("Malformed trace line: %s", line);
          end
        end
      end
      $fclose(fd);
    end
    n_lines = t_inst.size();
  endtask

  // Fetch offer that stays up until accepted
  task automatic offer_fetch();
    bit hold;
    hold = fetch_val && (offered == fetch_idx);
    if (fetch_idx >= n_lines) begin
      fetch_val = 1'b0;
      fetch_req = '0;
    end else begin
      if (!hold)
        fetch_val = ($urandom % 4) != 0;
      fetch_req.inst    = t_inst[fetch_idx];
      fetch_req.pc      = t_pc[fetch_idx];
      fetch_req.seq_num = fetch_idx[pipe_pkg::SEQ_BITS-1:0];
    end
    offered = fetch_idx;
  endtask

  // Age in-flight ops and strobe the oldest finished one
  task automatic strobe_completion();
    int i;
    int idx;
    i = 0;
    while (i < fly_line.size()) begin
      fly_wait[i] = fly_wait[i] - 1;
      if (fly_wait[i] <= 0) begin
        done_q.push_back(fly_line[i]);
        fly_line.delete(i);
        fly_wait.delete(i);
      end else begin
        i++;
      end
    end
    complete_val = 1'b0;
    complete     = '0;
    if (done_q.size() > 0) begin
      idx = done_q.pop_front();
      complete_val     = 1'b1;
      complete.waddr   = t_waddr[idx];
      complete.wdata   = t_result[idx];
      complete.wen     = (t_waddr[idx] != 0);
      complete.seq_num = idx[pipe_pkg::SEQ_BITS-1:0];
    end
  endtask

  // One transfer against trace line idx
  task automatic check_issue(input int idx, input logic [pipe_pkg::NUM_PIPES-1:0] xfer);
    logic [9:0]                     srcs;
    logic [pipe_pkg::NUM_PIPES-1:0] want;
    isa_pkg::rv_uop                 want_uop;
    checks++;
    if (idx >= n_lines) begin
      errors++;
      $display("ERROR at %0t: issue after the last trace line", $time);
    end else begin
      srcs = source_regs(t_inst[idx]);
      want = '0;
      want[t_pipe[idx]] = 1'b1;
      want_uop = expected_uop(t_inst[idx]);
      if (xfer != want) begin
        errors++;
        $display("ERROR at %0t: line %0d went to pipes %b, want %b", $time, idx, xfer, want);
      end
      if (issue.pc != t_pc[idx] || issue.seq_num != idx[pipe_pkg::SEQ_BITS-1:0]) begin
        errors++;
        $display("ERROR at %0t: line %0d pc %h seq %0d out of order", $time, idx,
                 issue.pc, issue.seq_num);
      end
      if (issue.uop != want_uop) begin
        errors++;
        $display("ERROR at %0t: line %0d uop %0d, want %0d", $time, idx,
                 issue.uop, want_uop);
      end
      if (issue.op1 != t_op1[idx] || issue.op2 != t_op2[idx]) begin
        errors++;
        $display("ERROR at %0t: line %0d op1 %h op2 %h, want %h %h", $time, idx,
                 issue.op1, issue.op2, t_op1[idx], t_op2[idx]);
      end
      if (issue.waddr != t_waddr[idx]) begin
        errors++;
        $display("ERROR at %0t: line %0d waddr %0d, want %0d", $time, idx,
                 issue.waddr, t_waddr[idx]);
      end
      // RAW on either source and WAW on the destination
      if (busy[srcs[9:5]] || busy[srcs[4:0]] || busy[t_waddr[idx]]) begin
        errors++;
        $display("ERROR at %0t: line %0d issued over a busy register", $time, idx);
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // Monitor on the rising edge
  // ----------------------------------------------------------------------
  always @(posedge clk) begin : monitor
    logic [pipe_pkg::NUM_PIPES-1:0] xfer;
    bit                             held;
    if (!rst) begin
      xfer = issue_val & issue_rdy;
      held = fetch_idx > issue_idx;
      if (held && xfer == '0 && fetch_rdy) begin
        errors++;
        $display("ERROR at %0t: fetch_rdy high while line %0d is held", $time, issue_idx);
      end
      if (!held && issue_val != '0) begin
        errors++;
        $display("ERROR at %0t: issue_val %b with no fetched line", $time, issue_val);
      end
      if (xfer != '0)
        check_issue(issue_idx, xfer);
      // Completion frees its register on this edge
      if (complete_val && complete.wen && complete.waddr != '0)
        busy[complete.waddr] = 1'b0;
      if (xfer != '0) begin
        if (issue_idx < n_lines && t_waddr[issue_idx] != 0)
          busy[t_waddr[issue_idx]] = 1'b1;
        fly_line.push_back(issue_idx);
        fly_wait.push_back(next_delay);
        issue_idx++;
      end
      if (fetch_val && fetch_rdy)
        fetch_idx++;
    end
  end

  // Hang guard scaled by trace length
  initial begin : watchdog
    wait (trace_loaded);
    repeat (n_lines * 40 + 200) @(posedge clk);
    $display("Timeout: the run did not finish in time, the DUT appears to hang");
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  initial begin : main
    rst          = 1'b1;
    fetch_val    = 1'b0;
    fetch_req    = '0;
    issue_rdy    = '0;
    complete_val = 1'b0;
    complete     = '0;
    errors       = 0;
    checks       = 0;
    fetch_idx    = 0;
    issue_idx    = 0;
    offered      = -1;
    busy         = '0;
    next_delay   = 1;
    trace_loaded = 1'b0;
    void'($urandom(24));
    load_trace();
    trace_loaded = 1'b1;
    // Eight rising edges in reset
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // Reset state before any stimulus
    @(posedge clk);
    checks++;
    if (issue_val != '0 || !fetch_rdy) begin
      errors++;
      $display("ERROR at %0t: after reset issue_val %b fetch_rdy %b", $time,
               issue_val, fetch_rdy);
    end
    while (issue_idx < n_lines || fly_line.size() > 0 || done_q.size() > 0) begin
      @(negedge clk);
      offer_fetch();
      for (int k = 0; k < pipe_pkg::NUM_PIPES; k++)
        issue_rdy[k] = ($urandom % 4) != 0;
      // Completion delay for an op issued at the next edge
      next_delay = 1 + ($urandom % 4);
      strobe_completion();
    end
    @(negedge clk);
    fetch_val    = 1'b0;
    issue_rdy    = '0;
    complete_val = 1'b0;
    repeat (2) @(negedge clk);
    if (busy != '0) begin
      errors++;
      $display("ERROR at %0t: registers still busy at end %h", $time, busy);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== decode_issue_unit.f ====
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/inst_decoder.sv
verilog/imm_gen.sv
verilog/regfile_pending.sv
verilog/issue_router.sv
verilog/decode_issue_unit.sv
tests/decode_issue_sva.sv
tests/decode_issue_tb.sv

// ==== Bender.yml ====
package:
  name: decode_issue_unit

sources:
  - verilog/isa_pkg.sv
  - verilog/pipe_pkg.sv
  - verilog/inst_decoder.sv
  - verilog/imm_gen.sv
  - verilog/regfile_pending.sv
  - verilog/issue_router.sv
  - verilog/decode_issue_unit.sv
  - target: test
    files:
      - tests/decode_issue_sva.sv
      - tests/decode_issue_tb.sv

// ==== tests/decode_issue_trace.txt ====
# inst(hex) pc(hex) pipe(dec) op1(hex) op2(hex) waddr(dec) result(hex)
# result is what the pipe model returns on completion; text after # is ignored
00500093 00000000 0 00000000 00000005 1  00000005  # addi x1, x0, 5
ffd00113 00000004 0 00000000 fffffffd 2  fffffffd  # addi x2, x0, -3
002081b3 00000008 0 00000005 fffffffd 3  00000002  # add  x3, x1, x2
02118233 0000000c 1 00000002 00000005 4  0000000a  # mul  x4, x3, x1
401202b3 00000010 0 0000000a 00000005 5  00000005  # sub  x5, x4, x1
12345337 00000014 0 00000000 12345000 6  12345000  # lui  x6, 0x12345
0f036393 00000018 0 12345000 000000f0 7  123450f0  # ori  x7, x6, 0xf0
0053c0b3 0000001c 0 123450f0 00000005 1  123450f5  # xor  x1, x7, x5
02108433 00000020 1 123450f5 123450f5 8  71220a79  # mul  x8, x1, x1
007474b3 00000024 0 71220a79 123450f0 9  10200070  # and  x9, x8, x7
7ff4f513 00000028 0 10200070 000007ff 10 00000070  # andi x10, x9, 0x7ff
00208033 0000002c 0 123450f5 fffffffd 0  123450f2  # add  x0, x1, x2
02a505b3 00000030 1 00000070 00000070 11 00003100  # mul  x11, x10, x10
023585b3 00000034 1 00003100 00000002 11 00006200  # mul  x11, x11, x3
fff58613 00000038 0 00006200 ffffffff 12 000061ff  # addi x12, x11, -1
004666b3 0000003c 0 000061ff 0000000a 13 000061ff  # or   x13, x12, x4
00100093 00000040 0 00000000 00000001 1  00000001  # addi x1, x0, 1
40d08733 00000044 0 00000001 000061ff 14 ffff9e02  # sub  x14, x1, x13
